// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= issueStage_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Output goes to the console, the status comes from the search for the pass line
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/hazardPkg.sv ====
`include "hazard_defines.svh"

package hazardPkg;

  typedef logic [`INSTR_W-1:0] instrT;  // One instruction word
  typedef logic [2:0] regIdT;           // Register number R0..R7
  typedef logic [4:0] opcodeT;          // Major opcode, bits 15:11

  // Registers read and written by one instruction
  typedef struct packed {
    regIdT rs;
    logic  rsValid;
    regIdT rt;
    logic  rtValid;
    regIdT rd;
    logic  rdValid;
  } regUseT;

  localparam regIdT LINK_REG = 3'd7;  // Return address register
  localparam regUseT NO_USE = '0;     // Touches no register

  function automatic opcodeT opcodeOf(instrT instr);
    return instr[`INSTR_W-1 -: 5];
  endfunction

  function automatic regIdT regHi(instrT instr);
    return instr[10:8];
  endfunction

  function automatic regIdT regMid(instrT instr);
    return instr[7:5];
  endfunction

  function automatic regIdT regLo(instrT instr);
    return instr[4:2];
  endfunction

endpackage

// ==== rtl/hazard_defines.svh ====
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Width of one instruction word
`define INSTR_W 16

// Pipeline stages a destination register stays in flight after issue,
// counting the stage that writes it back
`define PIPE_DEPTH 3

`endif

// ==== rtl/inflightScoreboard.sv ====
`timescale 1ns/10ps
`include "hazard_defines.svh"

module inflightScoreboard
  import hazardPkg::*;
#(
  parameter int DEPTH = `PIPE_DEPTH
)
(
  input  logic   clk,
  input  logic   rst,
  input  logic   push,
  input  regUseT pushUse,
  input  regUseT queryUse,
  output logic   hazard
);

  // The last stage writes the register file ahead of the read in the
  // same cycle, so only the DEPTH-1 younger stages can block a reader.
  localparam int SLOTS = DEPTH - 1;

  if (DEPTH < 2)
  begin : gDepthCheck
    $error("inflightScoreboard needs DEPTH of at least 2");
  end

  regIdT            slotRd [SLOTS];  // Slot 0 is the youngest
  logic [SLOTS-1:0] slotValid;
  logic [SLOTS-1:0] rsHit;
  logic [SLOTS-1:0] rtHit;

  // Valid bits, a bubble enters whenever nothing is pushed
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      slotValid <= '0;
    end
    else
    begin
      slotValid[0] <= push && pushUse.rdValid;
      for (int i = 1; i < SLOTS; i++)
      begin
        slotValid[i] <= slotValid[i-1];
      end
    end
  end

  // Destination numbers shift along with the valid bits
  always_ff @(posedge clk)
  begin
    slotRd[0] <= pushUse.rd;
    for (int i = 1; i < SLOTS; i++)
    begin
      slotRd[i] <= slotRd[i-1];
    end
  end

  // Compare both sources against every live slot
  always_comb
  begin
    for (int i = 0; i < SLOTS; i++)
    begin
      rsHit[i] = slotValid[i] && queryUse.rsValid && (slotRd[i] == queryUse.rs);
      rtHit[i] = slotValid[i] && queryUse.rtValid && (slotRd[i] == queryUse.rt);
    end
  end

  assign hazard = (|rsHit) || (|rtHit);

endmodule

// ==== rtl/issueStage.sv ====
`timescale 1ns/10ps
`include "hazard_defines.svh"

module issueStage
  import hazardPkg::*;
(
  input  logic   clk,
  input  logic   rst,

  // Instruction stream in
  input  logic   inValid,
  input  instrT  inInstr,
  output logic   inReady,

  // Issue slot, the pipeline never stalls behind it
  output logic   issueValid,
  output instrT  issueInstr,
  output regUseT issueUse
);

  regUseT decUse;  // Registers of the presented instruction
  logic   hazard;
  logic   push;    // Accept this edge

  regIdDecode decode_i (
    .instr  (inInstr),
    .regUse (decUse)
  );

  // The presented instruction is checked and, once accepted, recorded
  inflightScoreboard #(
    .DEPTH (`PIPE_DEPTH)
  ) board_i (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .pushUse  (decUse),
    .queryUse (decUse),
    .hazard   (hazard)
  );

  // Ready depends only on the presented instruction, never on inValid
  assign inReady = !hazard;
  assign push    = inValid && inReady;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      issueValid <= 1'b0;
    end
    else
    begin
      issueValid <= push;  // One cycle per accept
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      issueInstr <= inInstr;
      issueUse   <= decUse;
    end
  end

endmodule

// ==== rtl/regIdDecode.sv ====
`timescale 1ns/10ps
`include "hazard_defines.svh"

module regIdDecode
  import hazardPkg::*;
(
  input  instrT  instr,
  output regUseT regUse
);

  opcodeT op;
  regIdT  hi;
  regIdT  mid;
  regIdT  lo;

  assign op  = opcodeOf(instr);
  assign hi  = regHi(instr);   // Bits 10:8
  assign mid = regMid(instr);  // Bits 7:5
  assign lo  = regLo(instr);   // Bits 4:2

  // Register use per instruction class. Opcodes not named below
  // fall through with no registers.
  always_comb
  begin
    regUse = NO_USE;
    casez (op)
      5'b000??, 5'b00100:  // HALT, NOP, SIIC, RTI, J
      begin
        regUse = NO_USE;
      end

      5'b010??:  // ADDI, SUBI, XORI, ANDNI
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rd      = mid;
        regUse.rdValid = 1'b1;
      end

      5'b101??:  // ROLI, SLLI, RORI, SRLI
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rd      = mid;
        regUse.rdValid = 1'b1;
      end

      5'b1101?:  // ADD, SUB, XOR, ANDN and the rotates/shifts
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rt      = mid;
        regUse.rtValid = 1'b1;
        regUse.rd      = lo;
        regUse.rdValid = 1'b1;
      end

      5'b111??:  // SEQ, SLT, SLE, SCO
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rt      = mid;
        regUse.rtValid = 1'b1;
        regUse.rd      = lo;
        regUse.rdValid = 1'b1;
      end

      5'b11001:  // BTR
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rd      = lo;
        regUse.rdValid = 1'b1;
      end

      5'b011??:  // BEQZ, BNEZ, BLTZ, BGEZ
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
      end

      5'b00101:  // JR
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
      end

      5'b11000:  // LBI, immediate only
      begin
        regUse.rd      = hi;
        regUse.rdValid = 1'b1;
      end

      5'b10010:  // SLBI shifts the old value in
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rd      = hi;
        regUse.rdValid = 1'b1;
      end

      // ST reads Rt and LD writes it. Both are treated as doing both,
      // which costs a stall now and then but needs no split here.
      5'b1000?:
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rt      = mid;
        regUse.rtValid = 1'b1;
        regUse.rd      = mid;
        regUse.rdValid = 1'b1;
      end

      5'b10011:  // STU writes the updated base
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rt      = mid;
        regUse.rtValid = 1'b1;
        regUse.rd      = hi;
        regUse.rdValid = 1'b1;
      end

      5'b00110:  // JAL, link register both ways
      begin
        regUse.rt      = LINK_REG;
        regUse.rtValid = 1'b1;
        regUse.rd      = LINK_REG;
        regUse.rdValid = 1'b1;
      end

      5'b00111:  // JALR
      begin
        regUse.rs      = hi;
        regUse.rsValid = 1'b1;
        regUse.rt      = LINK_REG;
        regUse.rtValid = 1'b1;
        regUse.rd      = LINK_REG;
        regUse.rdValid = 1'b1;
      end

      default:
      begin
        regUse = NO_USE;
      end
    endcase
  end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/hazardPkg.sv
rtl/regIdDecode.sv
rtl/inflightScoreboard.sv
rtl/issueStage.sv
tb/clockGen.sv
tb/issueStage_sva.sv
tb/issueStage_tb.sv

// ==== tb/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
  input  logic resetReq,  // Extra reset from the tests
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 20;  // 40 ns period

  logic powerOnReset;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Two rising edges in reset, released on a falling edge
  initial
  begin
    powerOnReset = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    powerOnReset = 1'b0;
  end

  assign rst = powerOnReset || resetReq;

endmodule

// ==== tb/issueStage_sva.sv ====
`timescale 1ns/10ps
`include "hazard_defines.svh"

module issueStage_sva
  import hazardPkg::*;
(
  input logic                   clk,
  input logic                   rst,
  input logic                   inValid,
  input instrT                  inInstr,
  input logic                   inReady,
  input logic                   issueValid,
  input logic [`PIPE_DEPTH-2:0] slotValid  // Scoreboard valid bits
);

  // No accept, no issue in the next cycle
  assert property (@(posedge clk) disable iff (rst)
    !(inValid && inReady) |=> !issueValid)
    else $error("issueValid high after an edge without an accept");

  // Empty scoreboard never blocks
  assert property (@(posedge clk) disable iff (rst)
    (slotValid == '0) |-> inReady)
    else $error("inReady low with no instruction in flight");

  // A stalled source holds its instruction
  assert property (@(posedge clk) disable iff (rst)
    (inValid && !inReady) |=> (inValid && $stable(inInstr)))
    else $error("inInstr changed while stalled");

endmodule

// ==== tb/issueStage_tb.sv ====
`timescale 1ns/10ps
`include "hazard_defines.svh"

module issueStage_tb
  import hazardPkg::*;
();

  localparam int TEST_CYCLES    = 200;  // Rough sum of all tests
  localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;

  logic   clk;
  logic   rst;
  logic   resetReq;
  logic   inValid;
  instrT  inInstr;
  logic   inReady;
  logic   issueValid;
  instrT  issueInstr;
  regUseT issueUse;

  integer seed;
  int     errorCount;
  int     testCount;
  int     failedTests;
  int     testStartErrors;
  int     cycleCount;

  clockGen clock_i (.resetReq(resetReq), .clk(clk), .rst(rst));

  issueStage dut_i (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inInstr    (inInstr),
    .inReady    (inReady),
    .issueValid (issueValid),
    .issueInstr (issueInstr),
    .issueUse   (issueUse)
  );

  bind issueStage issueStage_sva sva_i (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inInstr    (inInstr),
    .inReady    (inReady),
    .issueValid (issueValid),
    .slotValid  (board_i.slotValid)
  );

  function automatic instrT makeInstr(opcodeT op, regIdT hi, regIdT mid, regIdT lo);
    return {op, hi, mid, lo, 2'b00};
  endfunction

  // Reference register use, by instruction class
  task automatic modelUse(input instrT instr, output regUseT expUse);
    opcodeT op;
    logic   readHi;
    logic   readMid;
    logic   writeHi;
    logic   writeMid;
    logic   writeLo;
    logic   linkBoth;
    op = instr[`INSTR_W-1 -: 5];
    {readHi, readMid, writeHi, writeMid, writeLo, linkBoth} = '0;
    if (op[4:2] == 3'b010 || op[4:2] == 3'b101)  // ALU and shift immediates
      {readHi, writeMid} = 2'b11;
    else if (op[4:1] == 4'b1101 || op[4:2] == 3'b111)  // Reg-reg ALU, set
      {readHi, readMid, writeLo} = 3'b111;
    else if (op == 5'b11001)  // BTR
      {readHi, writeLo} = 2'b11;
    else if (op[4:2] == 3'b011 || op == 5'b00101)  // Branches, JR
      readHi = 1'b1;
    else if (op == 5'b11000)  // LBI
      writeHi = 1'b1;
    else if (op == 5'b10010)  // SLBI
      {readHi, writeHi} = 2'b11;
    else if (op[4:1] == 4'b1000)  // ST, LD
      {readHi, readMid, writeMid} = 3'b111;
    else if (op == 5'b10011)  // STU
      {readHi, readMid, writeHi} = 3'b111;
    else if (op == 5'b00110)  // JAL
      linkBoth = 1'b1;
    else if (op == 5'b00111)  // JALR
      {readHi, linkBoth} = 2'b11;
    expUse = '0;
    if (readHi)
      {expUse.rs, expUse.rsValid} = {instr[10:8], 1'b1};
    if (readMid)
      {expUse.rt, expUse.rtValid} = {instr[7:5], 1'b1};
    if (writeHi)
      {expUse.rd, expUse.rdValid} = {instr[10:8], 1'b1};
    if (writeMid)
      {expUse.rd, expUse.rdValid} = {instr[7:5], 1'b1};
    if (writeLo)
      {expUse.rd, expUse.rdValid} = {instr[4:2], 1'b1};
    if (linkBoth)
      {expUse.rt, expUse.rtValid, expUse.rd, expUse.rdValid} = {3'd7, 1'b1, 3'd7, 1'b1};
  endtask

  task automatic checkInstr(instrT got, instrT exp, string what);
    if (got !== exp)
    begin
      errorCount++;
      $display("Error at %0t: %s instruction is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkUse(regUseT got, regUseT exp, string what);
    if (got !== exp)
    begin
      errorCount++;
      $display("Error at %0t: %s register use is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(logic got, logic exp, string what);
    if (got !== exp)
    begin
      errorCount++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(int got, int exp, string what);
    if (got != exp)
    begin
      errorCount++;
      $display("Error at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic idleCycles(int n);
    inValid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // Called on a falling edge, returns on the falling edge after the accept
  task automatic offerInstr(input instrT instr, output int stallCycles);
    stallCycles = 0;
    inValid     = 1'b1;
    inInstr     = instr;
    #1;
    while (!inReady)
    begin
      stallCycles++;
      @(negedge clk);
      #1;
    end
    @(posedge clk);  // Accept edge
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic sendAndCheck(instrT instr, int expStall, string what);
    int     stall;
    regUseT expUse;
    offerInstr(instr, stall);
    checkCount(stall, expStall, {what, " stall"});
    checkBit(issueValid, 1'b1, {what, " issueValid"});
    checkInstr(issueInstr, instr, what);
    modelUse(instr, expUse);
    checkUse(issueUse, expUse, what);
  endtask

  task automatic startTest();
    testStartErrors = errorCount;
    idleCycles(`PIPE_DEPTH);  // Drain the scoreboard
  endtask

  task automatic finishTest(string name);
    testCount++;
    if (errorCount != testStartErrors)
    begin
      failedTests++;
      $display("Test %s: %0d errors", name, errorCount - testStartErrors);
    end
    else
      $display("Test %s: ok", name);
  endtask

  task automatic testDecode();
    logic [31:0] rnd;
    startTest();
    checkBit(issueValid, 1'b0, "idle issueValid");
    for (int op = 0; op < 32; op++)  // Every opcode, so every class
    begin
      rnd = $random(seed);
      sendAndCheck({op[4:0], rnd[10:0]}, 0, "decode");
      idleCycles(`PIPE_DEPTH - 1);
    end
    finishTest("decode per class");
  endtask

  task automatic testRsStall();
    startTest();
    sendAndCheck(makeInstr(5'b11011, 3'd1, 3'd2, 3'd3), 0, "ADD R3");
    sendAndCheck(makeInstr(5'b01000, 3'd3, 3'd4, 3'd0), `PIPE_DEPTH - 1, "ADDI from R3");
    finishTest("rs read-after-write stall");
  endtask

  task automatic testRtStall();
    startTest();
    sendAndCheck(makeInstr(5'b10001, 3'd1, 3'd5, 3'd0), 0, "LD R5");
    sendAndCheck(makeInstr(5'b10000, 3'd0, 3'd5, 3'd0), `PIPE_DEPTH - 1, "ST R5");
    sendAndCheck(makeInstr(5'b01000, 3'd2, 3'd6, 3'd0), 0, "ADDI from R2");
    finishTest("rt and ST/LD stall");
  endtask

  task automatic testBackToBack();
    startTest();
    sendAndCheck(makeInstr(5'b11000, 3'd1, 3'd0, 3'd0), 0, "LBI R1");
    sendAndCheck(makeInstr(5'b11000, 3'd2, 3'd0, 3'd0), 0, "LBI R2");
    sendAndCheck(makeInstr(5'b11000, 3'd3, 3'd0, 3'd0), 0, "LBI R3");
    sendAndCheck(makeInstr(5'b01000, 3'd4, 3'd5, 3'd0), 0, "ADDI R4 to R5");
    sendAndCheck(makeInstr(5'b01001, 3'd6, 3'd0, 3'd0), 0, "SUBI R6 to R0");
    sendAndCheck(makeInstr(5'b11011, 3'd4, 3'd6, 3'd7), 0, "ADD R4 R6");
    finishTest("independent back-to-back");
  endtask

  task automatic testNoRegAndLink();
    startTest();
    sendAndCheck(makeInstr(5'b11011, 3'd1, 3'd2, 3'd3), 0, "ADD R3");
    sendAndCheck(makeInstr(5'b00000, 3'd3, 3'd3, 3'd3), 0, "HALT");
    sendAndCheck(makeInstr(5'b00100, 3'd3, 3'd3, 3'd3), 0, "J");
    sendAndCheck(makeInstr(5'b00001, 3'd3, 3'd3, 3'd3), 0, "NOP");
    sendAndCheck(makeInstr(5'b00110, 3'd0, 3'd0, 3'd0), 0, "JAL");
    sendAndCheck(makeInstr(5'b00101, 3'd7, 3'd0, 3'd0), `PIPE_DEPTH - 1, "JR R7");
    finishTest("register-free and R7");
  endtask

  task automatic testReset();
    startTest();
    sendAndCheck(makeInstr(5'b11011, 3'd1, 3'd2, 3'd3), 0, "ADD R3");
    inValid  = 1'b1;  // Would issue here if reset did not win
    inInstr  = makeInstr(5'b11000, 3'd5, 3'd0, 3'd0);
    resetReq = 1'b1;
    @(negedge clk);  // One edge in reset, ADD still in flight
    resetReq = 1'b0;
    inValid  = 1'b0;
    checkBit(issueValid, 1'b0, "issueValid after reset");
    sendAndCheck(makeInstr(5'b01000, 3'd3, 3'd4, 3'd0), 0, "ADDI from R3");
    finishTest("reset clears state");
  endtask

  initial
  begin : watchdog
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", cycleCount);
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    seed        = 32'hef1d;
    inValid     = 1'b0;
    inInstr     = '0;
    resetReq    = 1'b0;
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;
    @(negedge clk);
    while (rst)
      @(negedge clk);
    testDecode();
    testRsStall();
    testRtStall();
    testBackToBack();
    testNoRegAndLink();
    testReset();
    $display("Tests run %0d, tests failed %0d, errors %0d", testCount, failedTests, errorCount);
    if (errorCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
